// ==== hdl/adc_link_macros.svh ====
// ----------------------------------------------------------------------
// sample resolution and conversion timing constants for the ADC
// capture link
// ----------------------------------------------------------------------

`ifndef ADC_LINK_MACROS_SVH
`define ADC_LINK_MACROS_SVH

// bits per converted sample, shifted out MSB first
`define ADC_RESOLUTION 18

// ref_clk cycles from one convert pulse to the next
// must stay at or above CONV_WAIT + ADC_RESOLUTION + 2 so that a
// one-lane frame closes its gate before the next convert pulse
`define CONV_PERIOD 24

// cycles the converter needs after cnv before its data can be clocked out
`define CONV_WAIT 4

`endif

// ==== hdl/adc_link_pkg.sv ====
// ----------------------------------------------------------------------
// shared types for the ADC capture link: sample word and lane mode
// ----------------------------------------------------------------------

`default_nettype none

`include "adc_link_macros.svh"

package adc_link_pkg;

  // one converted sample as it leaves the deserializer
  typedef logic [`ADC_RESOLUTION-1:0] sample_t;

  // lane mode of a frame
  // in two-lane mode da carries the odd-weight bits from the top and
  // db the ones just below, so the word arrives in half the cycles
  typedef enum logic {
    LANE_ONE = 1'b0,
    LANE_TWO = 1'b1
  } lane_mode_e;

endpackage

`default_nettype wire

// ==== hdl/adc_frame_if.sv ====
// ----------------------------------------------------------------------
// frame control bundle between the conversion timer and the
// lane deserializer
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

interface adc_frame_if;

  import adc_link_pkg::*;

  // one-cycle pulse, coincides with cnv at the ADC pins
  logic       frame_start;

  // high for every cycle the ADC clock is let through
  logic       gate;

  // lane mode latched at frame_start, held for the whole frame
  lane_mode_e frame_mode;

  // high during the final gate cycle of the frame
  logic       last_bit;

  // the timer owns every frame signal
  modport timer (
    output frame_start,
    output gate,
    output frame_mode,
    output last_bit
  );

  // the deserializer only follows the frame
  modport deser (
    input  frame_start,
    input  gate,
    input  frame_mode,
    input  last_bit
  );

endinterface

`default_nettype wire

// ==== hdl/conv_timer.sv ====
// ----------------------------------------------------------------------
// conversion timer: period counter, convert pulse, clock gate window
// and frame markers for the deserializer
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "adc_link_macros.svh"

module conv_timer (
  input  logic       ref_clk,
  input  logic       rst,
  input  logic       enable,
  input  logic       two_lanes,
  output logic       cnv,
  output logic       clk_gate,
  adc_frame_if.timer frame
);

  import adc_link_pkg::*;

  // counter wide enough to reach the last cycle of the period
  localparam int CNT_W = $clog2(`CONV_PERIOD);

  // count values that mark the frame, with cnv at count zero
  localparam logic [CNT_W-1:0] PERIOD_END = CNT_W'(`CONV_PERIOD - 1);
  localparam logic [CNT_W-1:0] GATE_FIRST = CNT_W'(`CONV_WAIT + 1);
  localparam logic [CNT_W-1:0] LAST_ONE   = CNT_W'(`CONV_WAIT + `ADC_RESOLUTION);
  localparam logic [CNT_W-1:0] LAST_TWO   = CNT_W'(`CONV_WAIT + `ADC_RESOLUTION / 2);

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_next;
  logic             busy;
  logic             busy_next;
  logic             start;
  lane_mode_e       mode_q;
  lane_mode_e       mode_next;
  logic [CNT_W-1:0] last_cnt;
  logic             last_bit_q;

  // ---------------------------------------------------------------------
  // next-state decode
  // ---------------------------------------------------------------------

  always_comb begin
    // a new frame starts from idle or right at the end of a period, but
    // only while enable is high, so a running frame always completes
    start = enable && (!busy || (cnt == PERIOD_END));

    if (start) begin
      cnt_next = '0;
    end else if (busy && (cnt != PERIOD_END)) begin
      cnt_next = cnt + 1'b1;
    end else begin
      // idle holds the counter where it is
      cnt_next = cnt;
    end

    if (start) begin
      busy_next = 1'b1;
    end else if (cnt == PERIOD_END) begin
      busy_next = 1'b0;
    end else begin
      busy_next = busy;
    end

    // two_lanes is only looked at when a convert pulse is issued
    if (start) begin
      mode_next = two_lanes ? LANE_TWO : LANE_ONE;
    end else begin
      mode_next = mode_q;
    end

    // the gate length follows the latched mode, never the live input
    last_cnt = (mode_next == LANE_TWO) ? LAST_TWO : LAST_ONE;
  end

  // ---------------------------------------------------------------------
  // registered outputs
  // ---------------------------------------------------------------------

  always_ff @(posedge ref_clk) begin
    if (rst) begin
      cnt        <= '0;
      busy       <= 1'b0;
      mode_q     <= LANE_ONE;
      cnv        <= 1'b0;
      clk_gate   <= 1'b0;
      last_bit_q <= 1'b0;
    end else begin
      cnt        <= cnt_next;
      busy       <= busy_next;
      mode_q     <= mode_next;
      cnv        <= start;
      // gate window runs from CONV_WAIT+1 through the last bit count
      clk_gate   <= busy_next && (cnt_next >= GATE_FIRST) && (cnt_next <= last_cnt);
      last_bit_q <= busy_next && (cnt_next == last_cnt);
    end
  end

  // frame markers are the same registers that drive the pins
  assign frame.frame_start = cnv;
  assign frame.gate        = clk_gate;
  assign frame.frame_mode  = mode_q;
  assign frame.last_bit    = last_bit_q;

endmodule

`default_nettype wire

// ==== hdl/lane_deserializer.sv ====
// ----------------------------------------------------------------------
// lane deserializer: one- or two-lane shift assembly, output register
// with valid strobe, sticky overflow flag
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "adc_link_macros.svh"

module lane_deserializer (
  input  logic              ref_clk,
  input  logic              rst,
  input  logic              da,
  input  logic              db,
  input  logic              adc_dovf,
  adc_frame_if.deser        frame,
  output logic              adc_valid,
  output adc_link_pkg::sample_t adc_data,
  output logic              overflow
);

  import adc_link_pkg::*;

  localparam int RES = `ADC_RESOLUTION;

  // frame markers delayed by one cycle
  logic    gate_d;
  logic    last_d;

  // word under assembly and its value after the current shift
  sample_t shift_q;
  sample_t shift_next;

  // ---------------------------------------------------------------------
  // launch edge alignment
  // ---------------------------------------------------------------------

  // the ADC drives a new bit on the edge that ends a gate cycle, so the
  // bit is stable one cycle later, which is where the delayed gate sits
  always_ff @(posedge ref_clk) begin
    if (rst) begin
      gate_d <= 1'b0;
      last_d <= 1'b0;
    end else begin
      gate_d <= frame.gate;
      last_d <= frame.last_bit;
    end
  end

  // ---------------------------------------------------------------------
  // shift assembly
  // ---------------------------------------------------------------------

  // bits come in MSB first, new bits enter at the bottom
  // in two-lane mode da holds the heavier bit of each pair
  always_comb begin
    if (frame.frame_mode == LANE_TWO) begin
      shift_next = {shift_q[RES-3:0], da, db};
    end else begin
      shift_next = {shift_q[RES-2:0], da};
    end
  end

  always_ff @(posedge ref_clk) begin
    if (gate_d) begin
      shift_q <= shift_next;
    end else if (frame.frame_start) begin
      // each frame starts from a clean word
      // a cut-short frame then cannot leak old bits into the next one
      shift_q <= '0;
    end
  end

  // ---------------------------------------------------------------------
  // output register, valid strobe and overflow
  // ---------------------------------------------------------------------

  // the final bit is taken straight from the shift input so the word is
  // complete in the same edge, valid follows 2 cycles after the last gate
  // the output register holds while the next frame is being shifted
  always_ff @(posedge ref_clk) begin
    if (rst) begin
      adc_valid <= 1'b0;
      adc_data  <= '0;
      overflow  <= 1'b0;
    end else begin
      adc_valid <= last_d;
      if (last_d) begin
        adc_data <= shift_next;
      end
      // sticky until reset, set by any sample delivered during overflow
      if (adc_valid && adc_dovf) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/adc_link_top.sv ====
// ----------------------------------------------------------------------
// top level of the ADC capture link: conversion timer, frame bundle
// and lane deserializer
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module adc_link_top (
  input  logic                  ref_clk,
  input  logic                  rst,

  // run control and lane mode, mode is taken at each cnv
  input  logic                  enable,
  input  logic                  two_lanes,

  // serial data lanes from the converter
  input  logic                  da,
  input  logic                  db,

  // overflow level reported by the downstream consumer
  input  logic                  adc_dovf,

  // converter control
  output logic                  cnv,
  output logic                  clk_gate,

  // captured samples
  output logic                  adc_valid,
  output adc_link_pkg::sample_t adc_data,
  output logic                  overflow
);

  // frame control from the timer to the deserializer
  adc_frame_if frame_bus ();

  // convert pulse and gate window generation
  conv_timer i_timer (
    .ref_clk   (ref_clk),
    .rst       (rst),
    .enable    (enable),
    .two_lanes (two_lanes),
    .cnv       (cnv),
    .clk_gate  (clk_gate),
    .frame     (frame_bus.timer)
  );

  // sample assembly from the lanes
  lane_deserializer i_deser (
    .ref_clk   (ref_clk),
    .rst       (rst),
    .da        (da),
    .db        (db),
    .adc_dovf  (adc_dovf),
    .frame     (frame_bus.deser),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .overflow  (overflow)
  );

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
// ----------------------------------------------------------------------
// testbench clock and reset source
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module clk_gen (
  output logic ref_clk,
  output logic rst
);

  localparam int HALF_PERIOD_NS = 10;
  localparam int RESET_CYCLES   = 3;

  // free running 20 ns clock
  initial begin
    ref_clk = 1'b0;
    forever #HALF_PERIOD_NS ref_clk = ~ref_clk;
  end

  // reset held over the first rising edges, released on an edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge ref_clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/adc_link_assert.sv ====
// ----------------------------------------------------------------------
// concurrent checks on cnv spacing, gate window length and valid strobe
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "adc_link_macros.svh"

module adc_link_assert (
  input logic ref_clk,
  input logic rst,
  input logic enable,
  input logic two_lanes,
  input logic cnv,
  input logic clk_gate,
  input logic adc_valid
);

  localparam int RES  = `ADC_RESOLUTION;
  localparam int HALF = `ADC_RESOLUTION / 2;

  logic two_lanes_d;
  logic frame_two;

  // two_lanes as the timer saw it on the edge that raised cnv, then kept
  // for the rest of the frame
  always_ff @(posedge ref_clk) begin
    if (rst) begin
      two_lanes_d <= 1'b0;
      frame_two   <= 1'b0;
    end else begin
      two_lanes_d <= two_lanes;
      if (cnv) begin
        frame_two <= two_lanes_d;
      end
    end
  end

  // ---------------------------------------------------------------------
  // convert pulse spacing
  // ---------------------------------------------------------------------

  a_cnv_gap: assert property (@(posedge ref_clk) disable iff (rst)
    cnv |=> (!cnv)[*(`CONV_PERIOD - 1)])
    else $error("cnv repeated inside one conversion period");

  // with enable still high at the end of the period the next cnv follows
  a_cnv_period: assert property (@(posedge ref_clk) disable iff (rst)
    cnv ##(`CONV_PERIOD - 1) enable |=> cnv)
    else $error("cnv missing at the end of the conversion period");

  // ---------------------------------------------------------------------
  // gate window and valid strobe
  // ---------------------------------------------------------------------

  a_gate_start: assert property (@(posedge ref_clk) disable iff (rst)
    cnv |-> ##(`CONV_WAIT + 1) $rose(clk_gate))
    else $error("clk_gate did not open at the conversion wait");

  a_gate_two: assert property (@(posedge ref_clk) disable iff (rst)
    $rose(clk_gate) && frame_two |-> clk_gate[*HALF] ##1 !clk_gate)
    else $error("two-lane gate window has the wrong length");

  a_gate_one: assert property (@(posedge ref_clk) disable iff (rst)
    $rose(clk_gate) && !frame_two |-> clk_gate[*RES] ##1 !clk_gate)
    else $error("one-lane gate window has the wrong length");

  // valid lands 2 cycles after the last gate cycle and lasts one cycle
  a_valid_strobe: assert property (@(posedge ref_clk) disable iff (rst)
    $fell(clk_gate) |-> ##1 adc_valid ##1 !adc_valid)
    else $error("adc_valid strobe misplaced after the gate window");

endmodule

`default_nettype wire

// ==== bench/adc_link_tb.sv ====
// ----------------------------------------------------------------------
// testbench for the ADC capture link: stim file reader, ADC lane model,
// result checks and watchdog
// ----------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "adc_link_macros.svh"

module adc_link_tb;

  import adc_link_pkg::*;

  localparam string       STIM_FILE    = "bench/adc_link_stim.txt";
  localparam int          MAX_RECORDS  = 64;
  localparam int          GROUP_LEN    = 4;
  localparam int          MIN_GAP      = 12;
  localparam int          RESET_CYCLES = 3;
  localparam int          RES          = `ADC_RESOLUTION;
  localparam int unsigned LCG_SEED     = 43;
  localparam int unsigned LCG_MUL      = 32'd1664525;
  localparam int unsigned LCG_INC      = 32'd1013904223;

  logic    ref_clk;
  logic    rst;
  logic    enable;
  logic    two_lanes;
  logic    da;
  logic    db;
  logic    adc_dovf;
  logic    cnv;
  logic    clk_gate;
  logic    adc_valid;
  sample_t adc_data;
  logic    overflow;

  // records from the stim file, gap_len is non-zero at the start of a group
  int      rec_count;
  int      rec_lanes [MAX_RECORDS];
  sample_t rec_value [MAX_RECORDS];
  logic    rec_ovf   [MAX_RECORDS];
  int      gap_len   [MAX_RECORDS];

  // samples on their way through the DUT, oldest first
  sample_t exp_value [$];
  logic    exp_ovf   [$];
  int      exp_lanes [$];

  int unsigned rng_state;
  int          watchdog_cycles;
  logic        stim_ready;
  logic        ovf_acc;
  logic        en_last;
  int          delivered;
  int          since_cnv;

  clk_gen i_clk (
    .ref_clk (ref_clk),
    .rst     (rst)
  );

  adc_link_top uut (
    .ref_clk   (ref_clk),
    .rst       (rst),
    .enable    (enable),
    .two_lanes (two_lanes),
    .da        (da),
    .db        (db),
    .adc_dovf  (adc_dovf),
    .cnv       (cnv),
    .clk_gate  (clk_gate),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .overflow  (overflow)
  );

  bind adc_link_top adc_link_assert u_assert (
    .ref_clk   (ref_clk),
    .rst       (rst),
    .enable    (enable),
    .two_lanes (two_lanes),
    .cnv       (cnv),
    .clk_gate  (clk_gate),
    .adc_valid (adc_valid)
  );

  function automatic int unsigned lcg_next(input int unsigned state);
    return state * LCG_MUL + LCG_INC;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "run stopped at the first error");
  endtask

  // ---------------------------------------------------------------------
  // stim file and run length
  // ---------------------------------------------------------------------

  task automatic read_stim();
    int          fd;
    int          n;
    int          lanes;
    int          flag;
    logic [31:0] val;
    string       line;
    fd = $fopen(STIM_FILE, "r");
    assert (fd != 0) else stop_with_failure("could not open the stim file");
    rec_count = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // blank lines and comment lines carry no record
      if (n <= 1 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %h %d", lanes, val, flag);
      assert (n == 3) else stop_with_failure({"malformed stim record: ", line});
      assert (lanes == 1 || lanes == 2) else stop_with_failure("stim lane count not 1 or 2");
      assert ((val >> RES) == 0) else stop_with_failure("stim sample wider than the ADC word");
      assert (rec_count < MAX_RECORDS) else stop_with_failure("too many stim records");
      rec_lanes[rec_count] = lanes;
      rec_value[rec_count] = val[RES-1:0];
      rec_ovf[rec_count]   = (flag != 0);
      rec_count++;
    end
    $fclose(fd);
    assert (rec_count > 0) else stop_with_failure("stim file holds no records");
  endtask

  // the LCG picks the enable-low gap ahead of every group of records
  task automatic plan_gaps();
    int total;
    total = 0;
    for (int i = 0; i < rec_count; i++) begin
      if (i % GROUP_LEN == 0) begin
        rng_state  = lcg_next(rng_state);
        gap_len[i] = MIN_GAP + int'((rng_state >> 16) % 16);
      end else begin
        gap_len[i] = 0;
      end
      total += gap_len[i];
    end
    watchdog_cycles = RESET_CYCLES + 8 + rec_count * (`CONV_PERIOD + 4) + total;
  endtask

  // ---------------------------------------------------------------------
  // ADC lane model
  // ---------------------------------------------------------------------

  task automatic next_cycle();
    @(negedge ref_clk);
    since_cnv++;
  endtask

  // entered at the negedge of the cnv cycle, returns at the negedge after
  // the last gate cycle
  task automatic play_record(input int i);
    int      nbits;
    int      k;
    int      first_cyc;
    logic    g;
    sample_t v;
    nbits = (rec_lanes[i] == 2) ? RES / 2 : RES;
    v = rec_value[i];
    exp_value.push_back(v);
    exp_ovf.push_back(rec_ovf[i]);
    exp_lanes.push_back(rec_lanes[i]);
    k = 0;
    first_cyc = -1;
    while (k < nbits) begin
      g = clk_gate;
      if (g && first_cyc < 0) begin
        first_cyc = since_cnv;
        assert (first_cyc == `CONV_WAIT + 1) else stop_with_failure($sformatf(
          "Error gate_timing: expected gate at cycle %0d, actual %0d",
          `CONV_WAIT + 1, first_cyc));
      end
      if (first_cyc >= 0) begin
        assert (g) else stop_with_failure($sformatf(
          "Error gate_length: expected %0d cycles, actual %0d", nbits, k));
      end
      @(posedge ref_clk);
      // a new bit goes out on the edge that ends each gate cycle
      if (g) begin
        if (rec_lanes[i] == 2) begin
          da <= v[RES-1-2*k];
          db <= v[RES-2-2*k];
        end else begin
          da <= v[RES-1-k];
          // db is unused in one-lane mode and carries noise
          rng_state = lcg_next(rng_state);
          db <= rng_state[16];
        end
        if (k == nbits - 1) begin
          // dovf covers this sample's valid cycle
          adc_dovf <= rec_ovf[i];
          if (i + 1 < rec_count) begin
            two_lanes <= (rec_lanes[i+1] == 2);
          end
          // the group ends here, the running frame still completes
          if (i + 1 == rec_count || gap_len[i+1] > 0) begin
            enable <= 1'b0;
          end
        end
        k++;
      end
      next_cycle();
    end
    assert (!clk_gate) else stop_with_failure($sformatf(
      "Error gate_length: expected %0d cycles, actual more", nbits));
  endtask

  // ---------------------------------------------------------------------
  // output monitor, sampled on the falling edge
  // ---------------------------------------------------------------------

  always @(negedge ref_clk) begin
    if (stim_ready && !rst) begin
      assert (overflow == ovf_acc) else stop_with_failure($sformatf(
        "Error overflow_flag: expected %0b, actual %0b", ovf_acc, overflow));
      assert (!cnv || en_last) else stop_with_failure("cnv appeared while enable was low");
      if (adc_valid) begin
        assert (exp_value.size() > 0) else stop_with_failure(
          "adc_valid appeared with no sample in flight");
        assert (adc_data == exp_value[0]) else stop_with_failure($sformatf(
          "Error %s: expected %05h, actual %05h",
          (exp_lanes[0] == 2) ? "two_lane_capture" : "one_lane_capture",
          exp_value[0], adc_data));
        // overflow rises on the edge that ends the valid cycle
        ovf_acc = ovf_acc | exp_ovf[0];
        void'(exp_value.pop_front());
        void'(exp_ovf.pop_front());
        void'(exp_lanes.pop_front());
        delivered++;
      end
    end
    en_last = enable;
  end

  // ---------------------------------------------------------------------
  // watchdog
  // ---------------------------------------------------------------------

  initial begin
    wait (stim_ready);
    repeat (watchdog_cycles) @(posedge ref_clk);
    stop_with_failure($sformatf("timeout: run did not finish within %0d cycles",
      watchdog_cycles));
  end

  // ---------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------

  initial begin
    enable     = 1'b0;
    two_lanes  = 1'b0;
    da         = 1'b0;
    db         = 1'b0;
    adc_dovf   = 1'b0;
    stim_ready = 1'b0;
    ovf_acc    = 1'b0;
    en_last    = 1'b0;
    delivered  = 0;
    since_cnv  = 0;
    rng_state  = LCG_SEED;
    read_stim();
    plan_gaps();
    stim_ready = 1'b1;

    @(negedge ref_clk);
    while (rst) begin
      @(negedge ref_clk);
    end
    assert (!cnv && !clk_gate && !adc_valid && !overflow && adc_data == '0)
      else stop_with_failure("outputs not cleared after reset");

    for (int i = 0; i < rec_count; i++) begin
      if (gap_len[i] > 0) begin
        // idle gap with enable low, then the first cnv must follow at once
        repeat (gap_len[i]) @(posedge ref_clk);
        two_lanes <= (rec_lanes[i] == 2);
        enable    <= 1'b1;
        @(negedge ref_clk);
        assert (!cnv) else stop_with_failure("cnv came before enable was seen high");
        @(negedge ref_clk);
        assert (cnv) else stop_with_failure($sformatf(
          "Error enable_control: expected cnv %0b, actual %0b", 1'b1, cnv));
      end else begin
        while (!cnv) begin
          next_cycle();
        end
        assert (since_cnv == `CONV_PERIOD) else stop_with_failure($sformatf(
          "Error cnv_spacing: expected %0d, actual %0d", `CONV_PERIOD, since_cnv));
      end
      since_cnv = 0;
      play_record(i);
    end

    wait (delivered == rec_count);
    // a stray strobe in the tail would find an empty queue
    repeat (4) @(negedge ref_clk);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== adc_link_top.f ====
+incdir+hdl
hdl/adc_link_pkg.sv
hdl/adc_frame_if.sv
hdl/conv_timer.sv
hdl/lane_deserializer.sv
hdl/adc_link_top.sv
bench/clk_gen.sv
bench/adc_link_assert.sv
bench/adc_link_tb.sv

// ==== bench/adc_link_stim.txt ====
# one record per line, groups of four are separated by enable-low gaps
# columns: lanes (1 or 2)  sample (18-bit hex, MSB first on the wire)  dovf (0/1)
2 2A5C3 0
2 15A3C 0
1 3FFFF 0
1 2AAAA 0
2 00001 0
1 15555 0
2 20000 0
1 1E0F1 0
2 3FFFF 1
1 00000 0
2 0F0F0 0
1 30C3A 0
1 2468A 0
2 13579 1
